//--- src.f
src/l2_cfg_pkg.sv
src/l2_req_pkg.sv
src/l2_req_slave.sv
src/l2_bank_split.sv
src/l2_bank_array.sv
src/l2_resp_merge.sv
src/l2_host_domain.sv
tb/l2_checker.sv
tb/tb_l2_host_domain.sv

//--- tb/tb_l2_host_domain.sv
// Testbench for the L2 host domain
// Applies a table of writes and reads as four-phase transactions
`timescale 1ns/1ps
`default_nettype none

module tb_l2_host_domain;

  localparam int unsigned NumBanks    = 8;
  localparam int unsigned BankWords   = 64;
  localparam int unsigned AddrW       = $clog2(NumBanks*BankWords/2);
  localparam int          NumRandom   = 8;
  localparam int          NumEntries  = 16 + 2*NumRandom;
  localparam int          ResetCycles = 8;
  localparam int          CycleLimit  = ResetCycles + 10*NumEntries + 50;
  localparam int          DriveDelay  = 2;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   req_i;
  logic                   we_i;
  logic [AddrW-1:0]       addr_i;
  l2_req_pkg::host_be_t   be_i;
  l2_req_pkg::host_data_t wdata_i;
  logic                   ack_o;
  l2_req_pkg::host_data_t rdata_o;

  l2_req_pkg::host_data_t exp_rdata;
  int                     test_idx;
  int                     pass_cnt;
  int                     fail_cnt;
  int                     cycles = 0;
  int unsigned            seed;

  // Stimulus table
  logic                   tbl_we    [NumEntries];
  logic [AddrW-1:0]       tbl_addr  [NumEntries];
  l2_req_pkg::host_be_t   tbl_be    [NumEntries];
  l2_req_pkg::host_data_t tbl_wdata [NumEntries];
  l2_req_pkg::host_data_t tbl_exp   [NumEntries];
  int                     n_entries = 0;

  // Bank contents as the table expects them
  l2_cfg_pkg::bank_data_t model_mem [NumBanks][BankWords];

  l2_host_domain #(
    .NumBanks  ( NumBanks  ),
    .BankWords ( BankWords )
  ) u_l2_host_domain (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .req_i   ( req_i   ),
    .we_i    ( we_i    ),
    .addr_i  ( addr_i  ),
    .be_i    ( be_i    ),
    .wdata_i ( wdata_i ),
    .ack_o   ( ack_o   ),
    .rdata_o ( rdata_o )
  );

  l2_checker u_l2_checker (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .req_i       ( req_i     ),
    .ack_i       ( ack_o     ),
    .rdata_i     ( rdata_o   ),
    .exp_rdata_i ( exp_rdata ),
    .is_write_i  ( we_i      ),
    .test_idx_i  ( test_idx  ),
    .pass_cnt_o  ( pass_cnt  ),
    .fail_cnt_o  ( fail_cnt  )
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("Some tests failed");
      $finish;
    end
  end

  // Low half at bank 2A mod NumBanks, high half one bank up, same row
  task automatic add_entry(input logic we, input logic [AddrW-1:0] addr,
                           input l2_req_pkg::host_be_t be,
                           input l2_req_pkg::host_data_t wdata);
    int                     lo_bank;
    int                     row;
    l2_req_pkg::host_data_t word;
    lo_bank = (2*addr) % NumBanks;
    row     = (2*addr) / NumBanks;
    word    = {model_mem[lo_bank+1][row], model_mem[lo_bank][row]};
    if (we) begin
      for (int k = 0; k < 8; k++) begin
        if (be[k]) begin
          word[8*k +: 8] = wdata[8*k +: 8];
        end
      end
      model_mem[lo_bank][row]   = word[31:0];
      model_mem[lo_bank+1][row] = word[63:32];
      tbl_exp[n_entries] = '0;
    end else begin
      tbl_exp[n_entries] = word;
    end
    tbl_we[n_entries]    = we;
    tbl_addr[n_entries]  = addr;
    tbl_be[n_entries]    = be;
    tbl_wdata[n_entries] = wdata;
    n_entries++;
  endtask

  task automatic add_read(input logic [AddrW-1:0] addr);
    // Strobe and data are junk, a read must ignore them
    add_entry(1'b0, addr, l2_req_pkg::host_be_t'($urandom), {$urandom, $urandom});
  endtask

  task automatic build_table();
    logic [AddrW-1:0] rnd_addr [NumRandom];
    logic [AddrW-1:0] last;
    last = '1;
    for (int b = 0; b < NumBanks; b++) begin
      for (int r = 0; r < BankWords; r++) begin
        model_mem[b][r] = '0;
      end
    end
    // Neighbouring indices, a bank wrap and the last index
    add_entry(1'b1, 0, 8'hff, 64'h0123_4567_89ab_cdef);
    add_entry(1'b1, 1, 8'hff, 64'h1122_3344_5566_7788);
    add_entry(1'b1, 2, 8'hff, 64'hdead_beef_0bad_f00d);
    add_entry(1'b1, 3, 8'hff, 64'hcafe_f00d_1234_5678);
    add_entry(1'b1, 4, 8'hff, 64'h5a5a_a5a5_0f0f_f0f0);
    add_entry(1'b1, last, 8'hff, 64'hfedc_ba98_7654_3210);
    add_read(0);
    add_read(1);
    add_read(2);
    add_read(3);
    add_read(4);
    add_read(last);
    // Partial strobe over both halves
    add_entry(1'b1, 2, 8'ha5, 64'h9988_7766_5544_3322);
    add_read(2);
    add_read(1);
    add_read(3);
    for (int i = 0; i < NumRandom; i++) begin
      rnd_addr[i] = $urandom_range((1 << AddrW) - 1, 0);
      add_entry(1'b1, rnd_addr[i], 8'hff, {$urandom, $urandom});
    end
    for (int i = 0; i < NumRandom; i++) begin
      add_read(rnd_addr[i]);
    end
  endtask

  // Entered and left a short delay after a rising edge
  task automatic run_entry(input int idx);
    we_i      = tbl_we[idx];
    addr_i    = tbl_addr[idx];
    be_i      = tbl_be[idx];
    wdata_i   = tbl_wdata[idx];
    exp_rdata = tbl_exp[idx];
    test_idx  = idx;
    req_i     = 1'b1;
    do begin
      @(posedge clk_i);
      #(DriveDelay);
    end while (ack_o !== 1'b1);
    req_i = 1'b0;
    do begin
      @(posedge clk_i);
      #(DriveDelay);
    end while (ack_o !== 1'b0);
  endtask

  initial begin
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    req_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    be_i      = '0;
    wdata_i   = '0;
    exp_rdata = '0;
    test_idx  = -1;
    seed      = $urandom(32'hffa5);
    build_table();
    repeat (ResetCycles) @(posedge clk_i);
    #(DriveDelay);
    rst_n_i = 1'b1;
    @(posedge clk_i);
    #(DriveDelay);
    for (int i = 0; i < n_entries; i++) begin
      run_entry(i);
    end
    repeat (3) @(posedge clk_i);
    #(DriveDelay);
    $display("tests passed %0d, failed %0d, expected %0d", pass_cnt, fail_cnt, n_entries + 1);
    if (fail_cnt == 0 && pass_cnt == n_entries + 1) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/l2_checker.sv
// L2 host port checker
// Follows each req/ack transaction, checks read data and handshake timing
`timescale 1ns/1ps
`default_nettype none

module l2_checker (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_i,
  input  logic                   ack_i,
  input  l2_req_pkg::host_data_t rdata_i,
  input  l2_req_pkg::host_data_t exp_rdata_i,
  input  logic                   is_write_i,
  input  int                     test_idx_i,
  output int                     pass_cnt_o,
  output int                     fail_cnt_o
);

  localparam int AckLatency = 4;

  logic in_txn       = 1'b0;
  logic ack_seen     = 1'b0;
  logic drop_pending = 1'b0;
  logic reset_done   = 1'b0;
  logic req_q        = 1'b0;
  logic ack_q        = 1'b0;
  logic txn_write    = 1'b0;
  int   txn_idx      = 0;
  int   edges        = 0;
  int   errs         = 0;

  initial begin
    pass_cnt_o = 0;
    fail_cnt_o = 0;
  end

  task automatic close_test();
    if (errs == 0) begin
      pass_cnt_o++;
      $display("test %0d %s: passed", txn_idx, txn_write ? "write" : "read");
    end else begin
      fail_cnt_o++;
      $display("test %0d %s: %0d errors", txn_idx, txn_write ? "write" : "read", errs);
    end
  endtask

  task automatic check_reset_state();
    int bad;
    bad = 0;
    if (ack_i !== 1'b0) begin
      $display("Error: time %0t, ack_o expected 0, actual %b", $time, ack_i);
      bad++;
    end
    if (rdata_i !== '0) begin
      $display("Error: time %0t, rdata_o expected %h, actual %h", $time, 64'h0, rdata_i);
      bad++;
    end
    if (bad == 0) begin
      pass_cnt_o++;
      $display("test reset: passed");
    end else begin
      fail_cnt_o++;
      $display("test reset: %0d errors", bad);
    end
  endtask

  // Values seen here are the ones the DUT samples on the same edge
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_txn       = 1'b0;
      ack_seen     = 1'b0;
      drop_pending = 1'b0;
      req_q        = 1'b0;
      ack_q        = 1'b0;
    end else begin
      if (ack_i && !ack_q && !req_q) begin
        $display("ack_o rose at %0t without req_i being high", $time);
        fail_cnt_o++;
      end
      if (in_txn) begin
        edges++;
        if (drop_pending) begin
          if (ack_i !== 1'b0) begin
            $display("ack_o stayed high one edge after req_i was sampled low");
            errs++;
          end
          close_test();
          in_txn = 1'b0;
        end else if (!ack_seen) begin
          if (ack_i) begin
            ack_seen = 1'b1;
            // Seen one edge after the edge that raised it
            if (edges - 1 != AckLatency) begin
              $display("ack_o rose %0d cycles after the request, %0d expected",
                       edges - 1, AckLatency);
              errs++;
            end
            if (rdata_i !== exp_rdata_i) begin
              $display("Error: time %0t, rdata_o expected %h, actual %h",
                       $time, exp_rdata_i, rdata_i);
              errs++;
            end
            // The host may drop req_i on the edge that first sees ack_o
            if (!req_i) begin
              drop_pending = 1'b1;
            end
          end
        end else if (!ack_i) begin
          $display("ack_o fell at %0t while req_i was still high", $time);
          errs++;
        end else if (!req_i) begin
          drop_pending = 1'b1;
        end
      end
      // A new request can be sampled on the edge that closes the last one
      if (!in_txn && req_i && !ack_i) begin
        in_txn       = 1'b1;
        ack_seen     = 1'b0;
        drop_pending = 1'b0;
        edges        = 0;
        errs         = 0;
        txn_idx      = test_idx_i;
        txn_write    = is_write_i;
        if (!reset_done) begin
          reset_done = 1'b1;
          check_reset_state();
        end
      end
      req_q = req_i;
      ack_q = ack_i;
    end
  end

endmodule

`default_nettype wire

//--- src/l2_host_domain.sv
// L2 host domain
// Four-stage pipeline from a req/ack host port to interleaved 32-bit L2 banks
`timescale 1ns/1ps
`default_nettype none

module l2_host_domain #(
  parameter int unsigned NumBanks  = l2_cfg_pkg::NbL2Banks,
  parameter int unsigned BankWords = l2_cfg_pkg::L2BankSize
) (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     req_i,
  input  logic                                     we_i,
  input  logic [$clog2(NumBanks*BankWords/2)-1:0]  addr_i,
  input  l2_req_pkg::host_be_t                     be_i,
  input  l2_req_pkg::host_data_t                   wdata_i,
  output logic                                     ack_o,
  output l2_req_pkg::host_data_t                   rdata_o
);

  localparam int unsigned AddrW = $clog2(NumBanks*BankWords/2);
  localparam int unsigned BankW = $clog2(NumBanks);
  localparam int unsigned RowW  = $clog2(BankWords);

  // Intake to split
  logic                   acc_valid;
  logic                   acc_we;
  logic [AddrW-1:0]       acc_addr;
  l2_req_pkg::host_be_t   acc_be;
  l2_req_pkg::host_data_t acc_wdata;

  // Split to banks
  logic [NumBanks-1:0]                 bank_req;
  logic [NumBanks-1:0]                 bank_we;
  logic [NumBanks-1:0][RowW-1:0]       bank_row;
  l2_cfg_pkg::bank_be_t [NumBanks-1:0]   bank_be;
  l2_cfg_pkg::bank_data_t [NumBanks-1:0] bank_wdata;
  l2_cfg_pkg::bank_data_t [NumBanks-1:0] bank_rdata;

  // Split to merge, merge to intake
  logic                   pair_valid;
  logic [BankW-1:0]       pair_bank;
  logic                   resp_valid;
  l2_req_pkg::host_data_t resp_rdata;

  l2_req_slave #(
    .NumBanks  ( NumBanks  ),
    .BankWords ( BankWords )
  ) u_l2_req_slave (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .req_i        ( req_i      ),
    .we_i         ( we_i       ),
    .addr_i       ( addr_i     ),
    .be_i         ( be_i       ),
    .wdata_i      ( wdata_i    ),
    .resp_valid_i ( resp_valid ),
    .resp_rdata_i ( resp_rdata ),
    .ack_o        ( ack_o      ),
    .rdata_o      ( rdata_o    ),
    .acc_valid_o  ( acc_valid  ),
    .acc_we_o     ( acc_we     ),
    .acc_addr_o   ( acc_addr   ),
    .acc_be_o     ( acc_be     ),
    .acc_wdata_o  ( acc_wdata  )
  );

  l2_bank_split #(
    .NumBanks  ( NumBanks  ),
    .BankWords ( BankWords )
  ) u_l2_bank_split (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .acc_valid_i  ( acc_valid  ),
    .acc_we_i     ( acc_we     ),
    .acc_addr_i   ( acc_addr   ),
    .acc_be_i     ( acc_be     ),
    .acc_wdata_i  ( acc_wdata  ),
    .bank_req_o   ( bank_req   ),
    .bank_we_o    ( bank_we    ),
    .bank_row_o   ( bank_row   ),
    .bank_be_o    ( bank_be    ),
    .bank_wdata_o ( bank_wdata ),
    .pair_valid_o ( pair_valid ),
    .pair_bank_o  ( pair_bank  )
  );

  l2_bank_array #(
    .NumBanks  ( NumBanks  ),
    .BankWords ( BankWords )
  ) u_l2_bank_array (
    .clk_i        ( clk_i      ),
    .bank_req_i   ( bank_req   ),
    .bank_we_i    ( bank_we    ),
    .bank_row_i   ( bank_row   ),
    .bank_be_i    ( bank_be    ),
    .bank_wdata_i ( bank_wdata ),
    .bank_rdata_o ( bank_rdata )
  );

  l2_resp_merge #(
    .NumBanks ( NumBanks )
  ) u_l2_resp_merge (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .pair_valid_i ( pair_valid ),
    .pair_bank_i  ( pair_bank  ),
    .bank_rdata_i ( bank_rdata ),
    .resp_valid_o ( resp_valid ),
    .resp_rdata_o ( resp_rdata )
  );

endmodule

`default_nettype wire

//--- src/l2_resp_merge.sv
// L2 response merge
// Joins the even and odd bank read halves into one 64-bit response
`timescale 1ns/1ps
`default_nettype none

module l2_resp_merge #(
  parameter int unsigned NumBanks = l2_cfg_pkg::NbL2Banks
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   pair_valid_i,
  input  logic [$clog2(NumBanks)-1:0]            pair_bank_i,
  input  l2_cfg_pkg::bank_data_t [NumBanks-1:0]  bank_rdata_i,
  output logic                                   resp_valid_o,
  output l2_req_pkg::host_data_t                 resp_rdata_o
);

  localparam int unsigned BankW = $clog2(NumBanks);

  logic             pair_valid_q;
  logic [BankW-1:0] pair_bank_q;

  // Tag delayed to meet the bank read latency
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pair_valid_q <= 1'b0;
      resp_valid_o <= 1'b0;
    end else begin
      pair_valid_q <= pair_valid_i;
      resp_valid_o <= pair_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pair_valid_i) begin
      pair_bank_q <= pair_bank_i;
    end
    if (pair_valid_q) begin
      resp_rdata_o <= {bank_rdata_i[pair_bank_q | BankW'(1)], bank_rdata_i[pair_bank_q]};
    end
  end

  a_single_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_o |=> !resp_valid_o);

endmodule

`default_nettype wire

//--- src/l2_bank_array.sv
// L2 bank array
// One synchronous single-port memory per bank, with byte write enables
`timescale 1ns/1ps
`default_nettype none

module l2_bank_array #(
  parameter int unsigned NumBanks  = l2_cfg_pkg::NbL2Banks,
  parameter int unsigned BankWords = l2_cfg_pkg::L2BankSize
) (
  input  logic                                        clk_i,
  input  logic [NumBanks-1:0]                         bank_req_i,
  input  logic [NumBanks-1:0]                         bank_we_i,
  input  logic [NumBanks-1:0][$clog2(BankWords)-1:0]  bank_row_i,
  input  l2_cfg_pkg::bank_be_t [NumBanks-1:0]         bank_be_i,
  input  l2_cfg_pkg::bank_data_t [NumBanks-1:0]       bank_wdata_i,
  output l2_cfg_pkg::bank_data_t [NumBanks-1:0]       bank_rdata_o
);

  localparam int unsigned NumBytes = l2_cfg_pkg::L2DataWidth / 8;

  for (genvar b = 0; b < NumBanks; b++) begin : g_bank
    l2_cfg_pkg::bank_data_t mem_q [BankWords];

    always_ff @(posedge clk_i) begin
      if (bank_req_i[b]) begin
        if (bank_we_i[b]) begin
          for (int k = 0; k < NumBytes; k++) begin
            if (bank_be_i[b][k]) begin
              mem_q[bank_row_i[b]][8*k +: 8] <= bank_wdata_i[b][8*k +: 8];
            end
          end
        end else begin
          // Read data held until the next read of this bank
          bank_rdata_o[b] <= mem_q[bank_row_i[b]];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/l2_bank_split.sv
// L2 bank split
// Maps one 64-bit access onto two adjacent word-interleaved 32-bit banks
`timescale 1ns/1ps
`default_nettype none

module l2_bank_split #(
  parameter int unsigned NumBanks  = l2_cfg_pkg::NbL2Banks,
  parameter int unsigned BankWords = l2_cfg_pkg::L2BankSize
) (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  logic                                             acc_valid_i,
  input  logic                                             acc_we_i,
  input  logic [$clog2(NumBanks*BankWords/2)-1:0]          acc_addr_i,
  input  l2_req_pkg::host_be_t                             acc_be_i,
  input  l2_req_pkg::host_data_t                           acc_wdata_i,
  output logic [NumBanks-1:0]                              bank_req_o,
  output logic [NumBanks-1:0]                              bank_we_o,
  output logic [NumBanks-1:0][$clog2(BankWords)-1:0]       bank_row_o,
  output l2_cfg_pkg::bank_be_t [NumBanks-1:0]              bank_be_o,
  output l2_cfg_pkg::bank_data_t [NumBanks-1:0]            bank_wdata_o,
  output logic                                             pair_valid_o,
  output logic [$clog2(NumBanks)-1:0]                      pair_bank_o
);

  localparam int unsigned AddrW = $clog2(NumBanks*BankWords/2);
  localparam int unsigned BankW = $clog2(NumBanks);
  localparam logic [NumBanks-1:0] PairMask = 3;
  localparam logic [NumBanks-1:0] EvenMask = {(NumBanks/2){2'b01}};

  // 32-bit word index of the low half
  logic [AddrW:0]       word_idx;
  logic [BankW-1:0]     lo_bank;
  logic [AddrW-BankW:0] row;

  assign word_idx = {acc_addr_i, 1'b0};
  assign lo_bank  = word_idx[BankW-1:0];
  assign row      = word_idx[AddrW:BankW];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bank_req_o   <= '0;
      pair_valid_o <= 1'b0;
    end else begin
      bank_req_o   <= acc_valid_i ? (PairMask << lo_bank) : '0;
      pair_valid_o <= acc_valid_i;
    end
  end

  // Even banks always take the low half, odd banks the high half
  always_ff @(posedge clk_i) begin
    if (acc_valid_i) begin
      pair_bank_o <= lo_bank;
      for (int b = 0; b < NumBanks; b++) begin
        bank_we_o[b]    <= acc_we_i;
        bank_row_o[b]   <= row;
        bank_be_o[b]    <= (b % 2 == 1) ? acc_be_i[7:4] : acc_be_i[3:0];
        bank_wdata_o[b] <= (b % 2 == 1) ? acc_wdata_i[63:32] : acc_wdata_i[31:0];
      end
    end
  end

  // Two adjacent banks, the lower one even
  a_pair_shape: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bank_req_o == '0 ||
    ($countones(bank_req_o) == 2 &&
     bank_req_o == ((bank_req_o & EvenMask) | ((bank_req_o & EvenMask) << 1))));

endmodule

`default_nettype wire

//--- src/l2_req_slave.sv
// L2 request intake
// Runs the four-phase req/ack handshake and issues one captured access
`timescale 1ns/1ps
`default_nettype none

module l2_req_slave #(
  parameter int unsigned NumBanks  = l2_cfg_pkg::NbL2Banks,
  parameter int unsigned BankWords = l2_cfg_pkg::L2BankSize
) (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  input  logic                                            req_i,
  input  logic                                            we_i,
  input  logic [$clog2(NumBanks*BankWords/2)-1:0]         addr_i,
  input  l2_req_pkg::host_be_t                            be_i,
  input  l2_req_pkg::host_data_t                          wdata_i,
  input  logic                                            resp_valid_i,
  input  l2_req_pkg::host_data_t                          resp_rdata_i,
  output logic                                            ack_o,
  output l2_req_pkg::host_data_t                          rdata_o,
  output logic                                            acc_valid_o,
  output logic                                            acc_we_o,
  output logic [$clog2(NumBanks*BankWords/2)-1:0]         acc_addr_o,
  output l2_req_pkg::host_be_t                            acc_be_o,
  output l2_req_pkg::host_data_t                          acc_wdata_o
);

  l2_req_pkg::req_state_t state_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= l2_req_pkg::IDLE;
      ack_o       <= 1'b0;
      acc_valid_o <= 1'b0;
      rdata_o     <= '0;
    end else begin
      acc_valid_o <= 1'b0;
      case (state_q)
        l2_req_pkg::IDLE: begin
          if (req_i) begin
            state_q     <= l2_req_pkg::BUSY;
            acc_valid_o <= 1'b1;
          end
        end
        l2_req_pkg::BUSY: begin
          // Writes answer with zero
          if (resp_valid_i) begin
            state_q <= l2_req_pkg::ACK;
            ack_o   <= 1'b1;
            rdata_o <= acc_we_o ? '0 : resp_rdata_i;
          end
        end
        l2_req_pkg::ACK: begin
          if (!req_i) begin
            state_q <= l2_req_pkg::IDLE;
            ack_o   <= 1'b0;
          end
        end
        default: state_q <= l2_req_pkg::IDLE;
      endcase
    end
  end

  // Access captured once, on acceptance
  always_ff @(posedge clk_i) begin
    if (state_q == l2_req_pkg::IDLE && req_i) begin
      acc_we_o    <= we_i;
      acc_addr_o  <= addr_i;
      acc_be_o    <= be_i;
      acc_wdata_o <= wdata_i;
    end
  end

  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ack_o) |-> $past(req_i));

  a_acc_on_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_valid_o |-> state_q == l2_req_pkg::BUSY && $past(state_q) == l2_req_pkg::IDLE);

endmodule

`default_nettype wire

//--- src/l2_req_pkg.sv
// Host-side access types
// 64-bit data, byte strobe and the intake handshake states
`default_nettype none

package l2_req_pkg;

  localparam int unsigned HostDataWidth = 64;

  typedef logic [HostDataWidth-1:0] host_data_t;

  // Bit k enables byte k of host_data_t
  typedef logic [HostDataWidth/8-1:0] host_be_t;

  // Intake FSM
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    ACK  = 2'd2
  } req_state_t;

endpackage

`default_nettype wire

//--- src/l2_cfg_pkg.sv
// L2 bank geometry
// Default bank count and depth, plus the bank-side word types
`default_nettype none

package l2_cfg_pkg;

  // Must be a power of two, at least 2
  localparam int unsigned NbL2Banks = 8;

  // 32-bit words per bank, power of two
  localparam int unsigned L2BankSize = 16384;

  // Bank word width, fixed
  localparam int unsigned L2DataWidth = 32;

  typedef logic [L2DataWidth-1:0] bank_data_t;

  // One enable per byte of a bank word
  typedef logic [L2DataWidth/8-1:0] bank_be_t;

endpackage

`default_nettype wire
